// File: dv/tb_clkgen.sv
/*
 * testbench clock and reset generator
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin : clk_gen
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;  // 100 ns period
  end

  initial begin : rst_gen
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);  // two cycles in reset
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/tb_commit_stage.sv
/*
 * directed testbench of the commit stage: plain retirement,
 * jumps and branches, traps and mtval rules, mret, csr reads
 */

`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module tb_commit_stage;

  import commit_pkg::*;
  import csr_pkg::*;

  localparam int         TIMEOUT     = 20;  // cycles per wait
  localparam logic [6:0] OPC_OP      = 7'b011_0011;
  localparam logic [6:0] OPC_LOAD    = 7'b000_0011;
  localparam logic [6:0] OPC_STORE   = 7'b010_0011;
  localparam logic [6:0] OPC_JAL     = 7'b110_1111;
  localparam logic [6:0] OPC_BRANCH  = 7'b110_0011;
  localparam logic [6:0] OPC_SYSTEM  = 7'b111_0011;
  localparam xlen_t      INSTR_ECALL = 32'h0000_0073;
  localparam xlen_t      INSTR_MRET  = 32'h3020_0073;

  logic         clk, rst_n;
  logic         rob_valid, rob_ready, fe_ready;
  rob_entry_t   rob_head;
  rf_wr_t       rf_wr;
  logic         sb_pop, mis_flush, except_flush;
  fe_redirect_t fe_redirect;
  xlen_t        model_mepc;  // reference copy of mepc

  tb_clkgen u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  commit_stage dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .rob_valid_i    (rob_valid),
    .rob_head_i     (rob_head),
    .rob_ready_o    (rob_ready),
    .fe_ready_i     (fe_ready),
    .rf_wr_o        (rf_wr),
    .sb_pop_o       (sb_pop),
    .mis_flush_o    (mis_flush),
    .except_flush_o (except_flush),
    .fe_redirect_o  (fe_redirect)
  );

  // --------------------
  // reporting and timing helpers
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_val(input string test, input string what, input xlen_t exp_v,
                           input xlen_t act_v);
    assert (act_v === exp_v)
      else abort_run($sformatf("** Error [%s] %s: expected %h, actual %h",
                               test, what, exp_v, act_v));
  endtask

  task automatic check_bit(input string test, input string what, input logic exp_v,
                           input logic act_v);
    assert (act_v === exp_v)
      else abort_run($sformatf("** Error [%s] %s: expected %b, actual %b",
                               test, what, exp_v, act_v));
  endtask

  task automatic ensure(input string test, input logic cond, input string what);
    assert (cond === 1'b1) else abort_run($sformatf("%s: %s", test, what));
  endtask

  task automatic step();
    @(posedge clk);
    #1;  // drive and sample just after the edge
  endtask

  task automatic wait_ready(input string test);
    int cycles;
    cycles = 0;
    while (rob_ready !== 1'b1 && cycles < TIMEOUT) begin
      step();
      cycles++;
    end
    ensure(test, rob_ready, "timed out waiting for rob_ready");
  endtask

  task automatic wait_redirect(input string test, output int cycles);
    cycles = 0;
    while (fe_redirect.valid !== 1'b1 && cycles < TIMEOUT) begin
      step();
      cycles++;
    end
    ensure(test, fe_redirect.valid, "timed out waiting for the front-end redirect");
  endtask

  // --------------------
  // entry builders and retirement rules
  function automatic xlen_t rand_instr(input logic [6:0] opc);
    xlen_t r;
    r = $urandom();
    return {r[31:7], opc};  // upper fields are don't-care
  endfunction

  function automatic rob_entry_t new_entry(input xlen_t instr);
    rob_entry_t e;
    e           = '0;
    e.instr     = instr;
    e.pc        = $urandom() & 32'hffff_fffc;  // word aligned
    e.result    = $urandom();
    e.rd        = reg_addr_t'($urandom_range(31, 1));
    e.res_ready = 1'b1;
    return e;
  endfunction

  // one entry into the stage, valid dropped after the accepting edge
  task automatic accept(input string test, input rob_entry_t e);
    check_bit(test, "rob_ready before accept", 1'b1, rob_ready);
    rob_head  = e;
    rob_valid = 1'b1;
    step();
    rob_valid = 1'b0;
    rob_head  = '0;
  endtask

  task automatic check_quiet(input string test);
    check_bit(test, "rf we", 1'b0, rf_wr.we);
    check_bit(test, "sb_pop", 1'b0, sb_pop);
    check_bit(test, "mis_flush", 1'b0, mis_flush);
    check_bit(test, "except_flush", 1'b0, except_flush);
    check_bit(test, "redirect valid", 1'b0, fe_redirect.valid);
  endtask

  // side effect of a single-cycle retirement
  task automatic check_plain(input string test, input rob_entry_t e, input comm_type_t kind);
    logic we_exp;
    we_exp = (kind != COMM_TYPE_STORE) && (kind != COMM_TYPE_BRANCH);
    check_bit(test, "sb_pop", kind == COMM_TYPE_STORE, sb_pop);
    check_bit(test, "rf we", we_exp, rf_wr.we);
    check_bit(test, "mis_flush", 1'b0, mis_flush);
    check_bit(test, "except_flush", 1'b0, except_flush);
    check_bit(test, "redirect valid", 1'b0, fe_redirect.valid);
    check_bit(test, "rob_ready", 1'b1, rob_ready);  // stays open
    if (we_exp) begin
      check_val(test, "rf addr", xlen_t'(e.rd), xlen_t'(rf_wr.addr));
      check_val(test, "rf data", (kind == COMM_TYPE_JUMP) ? e.pc + 32'd4 : e.result,
                rf_wr.data);
    end
  endtask

  task automatic check_mispredict(input string test, input rob_entry_t e, input logic link);
    check_bit(test, "mis_flush", 1'b1, mis_flush);
    check_bit(test, "redirect valid", 1'b1, fe_redirect.valid);
    check_val(test, "redirect target", e.result, fe_redirect.target);
    check_bit(test, "rob_ready in flush", 1'b0, rob_ready);
    check_bit(test, "rf we", link, rf_wr.we);  // jal links, branch not
    if (link) begin
      check_val(test, "link addr", xlen_t'(e.rd), xlen_t'(rf_wr.addr));
      check_val(test, "link data", e.pc + 32'd4, rf_wr.data);
    end
    step();
    check_bit(test, "mis_flush after pulse", 1'b0, mis_flush);
    check_bit(test, "rob_ready after flush", 1'b1, rob_ready);
  endtask

  task automatic check_redirect(input string test, input xlen_t target);
    check_bit(test, "redirect valid", 1'b1, fe_redirect.valid);
    check_val(test, "redirect target", target, fe_redirect.target);
    check_bit(test, "rob_ready in redirect", 1'b0, rob_ready);
  endtask

  // hold fe_ready low a random while, then handshake
  task automatic hold_redirect(input string test, input xlen_t target);
    int hold;
    hold = $urandom_range(5, 0);
    repeat (hold) begin
      check_redirect(test, target);
      step();
    end
    check_redirect(test, target);
    fe_ready = 1'b1;
    step();
    fe_ready = 1'b0;
    check_bit(test, "redirect after handshake", 1'b0, fe_redirect.valid);
  endtask

  // csrrs rd, csr, x0 with the value landing in rd
  task automatic csr_read(input string test, input csr_addr_t addr, input xlen_t exp_v);
    rob_entry_t e;
    e       = new_entry('0);
    e.instr = {addr, 5'd0, 3'b010, e.rd, OPC_SYSTEM};
    accept(test, e);
    check_bit(test, "csr rf we", 1'b1, rf_wr.we);
    check_val(test, "csr rf addr", xlen_t'(e.rd), xlen_t'(rf_wr.addr));
    check_val(test, $sformatf("csr %h value", addr), exp_v, rf_wr.data);
    check_bit(test, "rob_ready in csr read", 1'b0, rob_ready);  // exactly one cycle
    step();
    check_bit(test, "rob_ready after csr read", 1'b1, rob_ready);
    check_bit(test, "rf we after csr read", 1'b0, rf_wr.we);
  endtask

  // --------------------
  // tests
  task automatic test_stream();
    string      test = "stream";
    rob_entry_t e;
    comm_type_t kind;
    logic [6:0] opc;
    int         pick;
    for (int i = 0; i < 10; i++) begin
      pick = $urandom_range(2, 0);
      kind = (pick == 0) ? COMM_TYPE_INT_RF : (pick == 1) ? COMM_TYPE_LOAD : COMM_TYPE_STORE;
      opc  = (pick == 0) ? OPC_OP : (pick == 1) ? OPC_LOAD : OPC_STORE;
      e    = new_entry(rand_instr(opc));
      check_bit(test, "rob_ready in stream", 1'b1, rob_ready);
      rob_head  = e;
      rob_valid = 1'b1;  // one entry per cycle
      step();
      check_plain(test, e, kind);
    end
    rob_valid = 1'b0;
    rob_head  = '0;
    step();
    check_quiet(test);
  endtask

  task automatic test_jumps();
    string      test = "jump_branch";
    rob_entry_t e;
    e = new_entry(rand_instr(OPC_JAL));
    accept(test, e);
    check_plain(test, e, COMM_TYPE_JUMP);
    e = new_entry(rand_instr(OPC_BRANCH));
    accept(test, e);
    check_plain(test, e, COMM_TYPE_BRANCH);
    e            = new_entry(rand_instr(OPC_JAL));
    e.mispredict = 1'b1;
    accept(test, e);
    check_mispredict(test, e, 1'b1);
    e            = new_entry(rand_instr(OPC_BRANCH));
    e.mispredict = 1'b1;
    accept(test, e);
    check_mispredict(test, e, 1'b0);
  endtask

  task automatic test_traps();
    string      test = "trap";
    rob_entry_t e;
    int         cycles;
    xlen_t      cause_exp;
    xlen_t      tval_exp;
    for (int i = 0; i < 3; i++) begin
      if (i == 0) begin
        e               = new_entry(rand_instr(OPC_LOAD));
        e.except_raised = 1'b1;
        e.except_code   = E_LD_ACCESS_FAULT;
        cause_exp       = 32'd5;     // load access fault
        tval_exp        = e.result;  // faulting address
      end else if (i == 1) begin
        e               = new_entry(rand_instr(OPC_OP));
        e.except_raised = 1'b1;
        e.except_code   = E_ILLEGAL_INSTR;
        cause_exp       = 32'd2;    // illegal instruction
        tval_exp        = e.instr;  // bad instr word
      end else begin
        e         = new_entry(INSTR_ECALL);
        cause_exp = 32'd11;  // ecall from m-mode
        tval_exp  = '0;
      end
      accept(test, e);
      check_bit(test, "except_flush", 1'b1, except_flush);  // mepc write cycle
      check_bit(test, "rob_ready in trap", 1'b0, rob_ready);
      step();
      check_bit(test, "except_flush after pulse", 1'b0, except_flush);
      wait_redirect(test, cycles);
      check_val(test, "cycles mcause to redirect", 32'd2, xlen_t'(cycles));
      hold_redirect(test, `MTVEC_RESET);
      wait_ready(test);
      model_mepc = e.pc;
      csr_read(test, CSR_MEPC, model_mepc);
      csr_read(test, CSR_MCAUSE, cause_exp);
      csr_read(test, CSR_MTVAL, tval_exp);
    end
  endtask

  task automatic test_mret();
    string      test = "mret";
    rob_entry_t e;
    int         cycles;
    e = new_entry(INSTR_MRET);
    accept(test, e);
    check_bit(test, "except_flush", 1'b1, except_flush);
    check_bit(test, "rob_ready in mret", 1'b0, rob_ready);
    step();
    check_bit(test, "except_flush after pulse", 1'b0, except_flush);
    wait_redirect(test, cycles);
    check_val(test, "cycles flush to redirect", 32'd0, xlen_t'(cycles));
    hold_redirect(test, model_mepc);  // return to saved pc
    check_bit(test, "rob_ready after mret", 1'b1, rob_ready);
  endtask

  task automatic test_csr_read();
    csr_read("csr_read", CSR_MTVEC, `MTVEC_RESET);
  endtask

  // --------------------
  initial begin : main
    void'($urandom(32'hd555));  // single seed for the run
    rob_valid  = 1'b0;
    rob_head   = '0;
    fe_ready   = 1'b0;
    model_mepc = '0;
    #1;
    check_bit("reset", "rob_ready in reset", 1'b0, rob_ready);
    check_quiet("reset");
    wait_ready("reset");
    check_quiet("reset");
    test_stream();
    test_jumps();
    test_traps();
    test_mret();
    test_csr_read();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+logic
logic/csr_pkg.sv
logic/commit_pkg.sv
logic/commit_decoder.sv
logic/commit_cu.sv
logic/commit_csrs.sv
logic/commit_stage.sv
dv/tb_clkgen.sv
dv/tb_commit_stage.sv

// File: logic/commit_csrs.sv
/*
 * machine-mode CSRs: mepc, mcause, mtval,
 * constant mtvec, combinational read-out
 */

`timescale 1ns/1ps
`default_nettype none

`include "commit_params.svh"

module commit_csrs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  csr_pkg::csr_wr_t       csr_wr_i,      // write req, addr is also read addr
  input  commit_pkg::rob_entry_t comm_entry_i,  // commit register
  output commit_pkg::xlen_t      csr_rdata_o
);

  import commit_pkg::*;
  import csr_pkg::*;

  xlen_t        mepc, mcause, mtval;
  xlen_t        wdata;
  except_code_t cause;

  // only ecall reaches the trap path without a raised exception
  assign cause = comm_entry_i.except_raised ? comm_entry_i.except_code : E_ECALL_M;

  always_comb begin : wdata_sel
    case (csr_wr_i.sel)
      CSR_SEL_RES:    wdata = comm_entry_i.result;  // fault address
      CSR_SEL_PC:     wdata = comm_entry_i.pc;
      CSR_SEL_EXCEPT: wdata = xlen_t'(cause);       // interrupt bit stays 0
      CSR_SEL_INSN:   wdata = comm_entry_i.instr;
      CSR_SEL_ZERO:   wdata = '0;
      default:        wdata = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : csr_upd
    if (!rst_n_i) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (csr_wr_i.valid) begin
      case (csr_wr_i.addr)
        CSR_MEPC:   mepc   <= wdata;
        CSR_MCAUSE: mcause <= wdata;
        CSR_MTVAL:  mtval  <= wdata;
        default: ;
      endcase
    end
  end

  // read port
  always_comb begin : csr_read
    case (csr_wr_i.addr)
      CSR_MEPC:   csr_rdata_o = mepc;
      CSR_MCAUSE: csr_rdata_o = mcause;
      CSR_MTVAL:  csr_rdata_o = mtval;
      CSR_MTVEC:  csr_rdata_o = `MTVEC_RESET;
      default:    csr_rdata_o = '0;  // unimplemented csr reads as zero
    endcase
  end

  a_mtvec_ro: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_wr_i.valid |-> (csr_wr_i.addr != CSR_MTVEC))
    else $error("write to read-only mtvec");

endmodule

`default_nettype wire

// File: logic/commit_cu.sv
/*
 * commit control unit: retirement FSM, commit register,
 * rf / store buffer / flush / redirect sequencing, CSR writes
 */

`timescale 1ns/1ps
`default_nettype none

module commit_cu (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     rob_valid_i,
  input  commit_pkg::rob_entry_t   rob_head_i,
  input  commit_pkg::comm_type_t   comm_type_i,   // from decoder
  output logic                     rob_ready_o,
  input  logic                     fe_ready_i,
  input  commit_pkg::xlen_t        csr_rdata_i,   // addressed csr
  output csr_pkg::csr_wr_t         csr_wr_o,
  output commit_pkg::rob_entry_t   comm_entry_o,  // commit register
  output commit_pkg::rf_wr_t       rf_wr_o,
  output logic                     sb_pop_o,
  output logic                     mis_flush_o,
  output logic                     except_flush_o,
  output commit_pkg::fe_redirect_t fe_redirect_o
);

  import commit_pkg::*;
  import csr_pkg::*;

  typedef enum logic [4:0] {
    RESET, IDLE,
    COMMIT_INT_RF, COMMIT_LOAD, COMMIT_STORE,
    COMMIT_JUMP, COMMIT_JUMP_MIS, COMMIT_BRANCH, COMMIT_BRANCH_MIS,
    COMMIT_CSR, COMMIT_OTHER,
    COMMIT_EXCEPT, EXCEPT_WRITE_CODE,                         // mepc, then mcause
    EXCEPT_SAVE_ADDR, EXCEPT_SAVE_INSTR, EXCEPT_CLEAR_MTVAL,  // mtval variants
    EXCEPT_LOAD_PC,                                           // jump to mtvec
    COMMIT_MRET, MRET_LOAD_PC,
    CLEAR_COMM_REG
  } cu_state_t;

  cu_state_t  curr_state, next_state, v_next_state;
  rob_entry_t comm_reg;
  logic       comm_reg_clr;
  xlen_t      link_addr;

  assign link_addr    = comm_reg.pc + xlen_t'(4);  // jal/jalr rd value
  assign comm_entry_o = comm_reg;

  // --------------------
  // next state on a valid head entry
  always_comb begin : valid_next_state
    case (comm_type_i)
      COMM_TYPE_INT_RF: v_next_state = COMMIT_INT_RF;
      COMM_TYPE_LOAD:   v_next_state = COMMIT_LOAD;
      COMM_TYPE_STORE:  v_next_state = COMMIT_STORE;
      COMM_TYPE_JUMP:   v_next_state = rob_head_i.mispredict ? COMMIT_JUMP_MIS : COMMIT_JUMP;
      COMM_TYPE_BRANCH: v_next_state = rob_head_i.mispredict ? COMMIT_BRANCH_MIS : COMMIT_BRANCH;
      COMM_TYPE_CSR:    v_next_state = COMMIT_CSR;
      COMM_TYPE_ECALL,
      COMM_TYPE_EXCEPT: v_next_state = COMMIT_EXCEPT;  // same trap sequence
      COMM_TYPE_MRET:   v_next_state = COMMIT_MRET;
      COMM_TYPE_OTHER:  v_next_state = COMMIT_OTHER;
      default:          v_next_state = IDLE;  // NONE, popped silently
    endcase
  end

  // --------------------
  // state progression
  always_comb begin : state_prog
    case (curr_state)
      RESET: next_state = IDLE;
      IDLE, COMMIT_INT_RF, COMMIT_LOAD, COMMIT_STORE,
      COMMIT_JUMP, COMMIT_BRANCH, COMMIT_OTHER:
        next_state = rob_valid_i ? v_next_state : IDLE;  // back-to-back retire
      COMMIT_JUMP_MIS, COMMIT_BRANCH_MIS,
      COMMIT_CSR, CLEAR_COMM_REG: next_state = IDLE;
      COMMIT_EXCEPT: next_state = EXCEPT_WRITE_CODE;
      EXCEPT_WRITE_CODE: begin
        if (!comm_reg.except_raised) begin
          next_state = EXCEPT_CLEAR_MTVAL;  // ecall, no mtval info
        end else begin
          case (comm_reg.except_code)
            E_I_ADDR_MISALIGNED, E_I_ACCESS_FAULT, E_BREAKPOINT,
            E_LD_ADDR_MISALIGNED, E_LD_ACCESS_FAULT,
            E_ST_ADDR_MISALIGNED, E_ST_ACCESS_FAULT: next_state = EXCEPT_SAVE_ADDR;
            E_ILLEGAL_INSTR:                         next_state = EXCEPT_SAVE_INSTR;
            default:                                 next_state = EXCEPT_CLEAR_MTVAL;
          endcase
        end
      end
      EXCEPT_SAVE_ADDR, EXCEPT_SAVE_INSTR,
      EXCEPT_CLEAR_MTVAL: next_state = EXCEPT_LOAD_PC;
      EXCEPT_LOAD_PC: next_state = fe_ready_i ? CLEAR_COMM_REG : EXCEPT_LOAD_PC;
      COMMIT_MRET:    next_state = MRET_LOAD_PC;
      MRET_LOAD_PC:   next_state = fe_ready_i ? IDLE : MRET_LOAD_PC;
      default:        next_state = RESET;
    endcase
  end

  // --------------------
  // outputs, decoded from state and commit register
  always_comb begin : out_eval
    rob_ready_o          = 1'b0;
    comm_reg_clr         = 1'b0;
    rf_wr_o.we           = 1'b0;
    rf_wr_o.addr         = comm_reg.rd;
    rf_wr_o.data         = comm_reg.result;
    sb_pop_o             = 1'b0;
    mis_flush_o          = 1'b0;
    except_flush_o       = 1'b0;
    fe_redirect_o.valid  = 1'b0;
    fe_redirect_o.target = comm_reg.result;  // corrected target on mispredict
    csr_wr_o.valid       = 1'b0;
    csr_wr_o.addr        = CSR_MEPC;
    csr_wr_o.sel         = CSR_SEL_RES;

    case (curr_state)
      IDLE, COMMIT_BRANCH, COMMIT_OTHER: rob_ready_o = 1'b1;
      COMMIT_INT_RF, COMMIT_LOAD: begin
        rob_ready_o = 1'b1;
        rf_wr_o.we  = 1'b1;  // result to rd
      end
      COMMIT_STORE: begin
        rob_ready_o = 1'b1;
        sb_pop_o    = 1'b1;
      end
      COMMIT_JUMP: begin
        rob_ready_o  = 1'b1;
        rf_wr_o.we   = 1'b1;
        rf_wr_o.data = link_addr;
      end
      COMMIT_JUMP_MIS: begin
        rf_wr_o.we          = 1'b1;
        rf_wr_o.data        = link_addr;
        mis_flush_o         = 1'b1;
        fe_redirect_o.valid = 1'b1;
        comm_reg_clr        = 1'b1;
      end
      COMMIT_BRANCH_MIS: begin
        mis_flush_o         = 1'b1;
        fe_redirect_o.valid = 1'b1;
        comm_reg_clr        = 1'b1;
      end
      COMMIT_CSR: begin
        csr_wr_o.addr = csr_addr_t'(comm_reg.instr[31:20]);  // read only
        rf_wr_o.we    = 1'b1;
        rf_wr_o.data  = csr_rdata_i;
      end
      COMMIT_EXCEPT: begin
        except_flush_o = 1'b1;
        csr_wr_o.valid = 1'b1;  // pc -> mepc
        csr_wr_o.sel   = CSR_SEL_PC;
      end
      EXCEPT_WRITE_CODE: begin
        csr_wr_o.valid = 1'b1;
        csr_wr_o.addr  = CSR_MCAUSE;
        csr_wr_o.sel   = CSR_SEL_EXCEPT;
      end
      EXCEPT_SAVE_ADDR, EXCEPT_SAVE_INSTR, EXCEPT_CLEAR_MTVAL: begin
        csr_wr_o.valid = 1'b1;
        csr_wr_o.addr  = CSR_MTVAL;
        if (curr_state == EXCEPT_SAVE_INSTR) csr_wr_o.sel = CSR_SEL_INSN;
        else if (curr_state == EXCEPT_CLEAR_MTVAL) csr_wr_o.sel = CSR_SEL_ZERO;
      end
      EXCEPT_LOAD_PC: begin
        csr_wr_o.addr        = CSR_MTVEC;  // handler base
        fe_redirect_o.valid  = 1'b1;
        fe_redirect_o.target = csr_rdata_i;
      end
      COMMIT_MRET: except_flush_o = 1'b1;
      MRET_LOAD_PC: begin
        fe_redirect_o.valid  = 1'b1;  // csr addr defaults to mepc
        fe_redirect_o.target = csr_rdata_i;
      end
      CLEAR_COMM_REG: comm_reg_clr = 1'b1;
      default: ;
    endcase
  end

  // --------------------
  // state and commit register
  always_ff @(posedge clk_i or negedge rst_n_i) begin : state_upd
    if (!rst_n_i) curr_state <= RESET;
    else curr_state <= next_state;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin : comm_reg_upd
    if (!rst_n_i) comm_reg <= '0;
    else if (rob_valid_i && rob_ready_o) comm_reg <= rob_head_i;  // accept
    else if (comm_reg_clr) comm_reg <= '0;
  end

  // --------------------
  // rob only offers result-carrying entries once the result exists
  a_res_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rob_valid_i && comm_type_i inside {COMM_TYPE_INT_RF, COMM_TYPE_LOAD,
                                        COMM_TYPE_STORE, COMM_TYPE_CSR})
    |-> rob_head_i.res_ready)
    else $error("rob offered an entry whose result is not ready");

  a_no_redirect_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (curr_state == IDLE) |-> !fe_redirect_o.valid)
    else $error("front-end redirect while idle");

  a_pop_xor_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(sb_pop_o && rf_wr_o.we))
    else $error("store buffer pop together with an rf write");

endmodule

`default_nettype wire

// File: logic/commit_decoder.sv
/*
 * commit decoder: classifies the rob head entry
 * by opcode, funct3 and imm into a commit type
 */

`timescale 1ns/1ps
`default_nettype none

module commit_decoder (
  input  commit_pkg::xlen_t      instr_i,          // head instr word
  input  logic                   except_raised_i,  // exception flag from rob
  output commit_pkg::comm_type_t comm_type_o
);

  import commit_pkg::*;

  // rv32 opcode classes
  localparam logic [6:0] OPC_OP     = 7'b011_0011;
  localparam logic [6:0] OPC_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OPC_LUI    = 7'b011_0111;
  localparam logic [6:0] OPC_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OPC_LOAD   = 7'b000_0011;
  localparam logic [6:0] OPC_STORE  = 7'b010_0011;
  localparam logic [6:0] OPC_JAL    = 7'b110_1111;
  localparam logic [6:0] OPC_JALR   = 7'b110_0111;
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;
  localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

  // priv encodings in imm field
  localparam logic [11:0] IMM_ECALL = 12'h000;
  localparam logic [11:0] IMM_MRET  = 12'h302;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] imm;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign imm    = instr_i[31:20];

  always_comb begin : type_decode
    comm_type_o = COMM_TYPE_OTHER;  // fence, misc-mem and unknown
    if (except_raised_i) begin
      comm_type_o = COMM_TYPE_EXCEPT;  // exception wins over opcode
    end else if (opcode[1:0] != 2'b11) begin
      comm_type_o = COMM_TYPE_NONE;  // not a 32-bit encoding
    end else begin
      case (opcode)
        OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: comm_type_o = COMM_TYPE_INT_RF;
        OPC_LOAD:                               comm_type_o = COMM_TYPE_LOAD;
        OPC_STORE:                              comm_type_o = COMM_TYPE_STORE;
        OPC_JAL, OPC_JALR:                      comm_type_o = COMM_TYPE_JUMP;
        OPC_BRANCH:                             comm_type_o = COMM_TYPE_BRANCH;
        OPC_SYSTEM: begin
          if (funct3 != 3'b000) comm_type_o = COMM_TYPE_CSR;    // csrr*
          else if (imm == IMM_ECALL) comm_type_o = COMM_TYPE_ECALL;
          else if (imm == IMM_MRET) comm_type_o = COMM_TYPE_MRET;
          else comm_type_o = COMM_TYPE_OTHER;  // ebreak, wfi
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/commit_params.svh
/*
 * global widths of the commit stage
 * trap vector reset value
 */

`ifndef COMMIT_PARAMS_SVH_
`define COMMIT_PARAMS_SVH_

// data and address width
`define XLEN 32

// integer register index width
`define REG_ADDR_W 5

// trap handler base, mtvec is read-only here
`define MTVEC_RESET 32'h0000_0100

`endif

// File: logic/commit_pkg.sv
/*
 * commit types: commit type enum, rob head entry,
 * register file write port, front-end redirect
 */

`default_nettype none

`include "commit_params.svh"

package commit_pkg;

  typedef logic [`XLEN-1:0]       xlen_t;      // data, pc
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;  // rf index

  // classification of the head entry
  typedef enum logic [3:0] {
    COMM_TYPE_NONE,    // nothing to retire
    COMM_TYPE_INT_RF,  // alu result to rd
    COMM_TYPE_LOAD,
    COMM_TYPE_STORE,
    COMM_TYPE_JUMP,    // jal / jalr, link to rd
    COMM_TYPE_BRANCH,
    COMM_TYPE_CSR,     // csr read to rd
    COMM_TYPE_ECALL,
    COMM_TYPE_MRET,
    COMM_TYPE_EXCEPT,
    COMM_TYPE_OTHER    // fence, ebreak, wfi
  } comm_type_t;

  // rob head entry, also the commit register
  typedef struct packed {
    xlen_t                 instr;
    xlen_t                 pc;
    xlen_t                 result;          // alu result, target or fault address
    reg_addr_t             rd;
    logic                  res_ready;
    logic                  mispredict;
    logic                  except_raised;
    csr_pkg::except_code_t except_code;
  } rob_entry_t;

  // integer rf write port
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    xlen_t     data;
  } rf_wr_t;

  // front-end redirect
  typedef struct packed {
    logic  valid;
    xlen_t target;
  } fe_redirect_t;

endpackage

`default_nettype wire

// File: logic/commit_stage.sv
/*
 * commit stage top: decoder, control unit and CSR block
 */

`timescale 1ns/1ps
`default_nettype none

module commit_stage (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     rob_valid_i,
  input  commit_pkg::rob_entry_t   rob_head_i,
  output logic                     rob_ready_o,
  input  logic                     fe_ready_i,
  output commit_pkg::rf_wr_t       rf_wr_o,
  output logic                     sb_pop_o,
  output logic                     mis_flush_o,
  output logic                     except_flush_o,
  output commit_pkg::fe_redirect_t fe_redirect_o
);

  import commit_pkg::*;
  import csr_pkg::*;

  comm_type_t comm_type;   // head classification
  csr_wr_t    csr_wr;      // cu -> csrs
  rob_entry_t comm_entry;  // commit register
  xlen_t      csr_rdata;

  commit_decoder u_decoder (
    .instr_i         (rob_head_i.instr),
    .except_raised_i (rob_head_i.except_raised),
    .comm_type_o     (comm_type)
  );

  commit_cu u_cu (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rob_valid_i    (rob_valid_i),
    .rob_head_i     (rob_head_i),
    .comm_type_i    (comm_type),
    .rob_ready_o    (rob_ready_o),
    .fe_ready_i     (fe_ready_i),
    .csr_rdata_i    (csr_rdata),
    .csr_wr_o       (csr_wr),
    .comm_entry_o   (comm_entry),
    .rf_wr_o        (rf_wr_o),
    .sb_pop_o       (sb_pop_o),
    .mis_flush_o    (mis_flush_o),
    .except_flush_o (except_flush_o),
    .fe_redirect_o  (fe_redirect_o)
  );

  commit_csrs u_csrs (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .csr_wr_i     (csr_wr),
    .comm_entry_i (comm_entry),
    .csr_rdata_o  (csr_rdata)
  );

endmodule

`default_nettype wire

// File: logic/csr_pkg.sv
/*
 * machine-mode CSR types: addresses, exception codes,
 * write data select and the CSR write request
 */

`default_nettype none

package csr_pkg;

  // machine-mode CSR addresses
  typedef enum logic [11:0] {
    CSR_MTVEC  = 12'h305,
    CSR_MEPC   = 12'h341,
    CSR_MCAUSE = 12'h342,
    CSR_MTVAL  = 12'h343
  } csr_addr_t;

  // synchronous exception codes, mcause[3:0]
  typedef enum logic [3:0] {
    E_I_ADDR_MISALIGNED  = 4'd0,
    E_I_ACCESS_FAULT     = 4'd1,
    E_ILLEGAL_INSTR      = 4'd2,
    E_BREAKPOINT         = 4'd3,
    E_LD_ADDR_MISALIGNED = 4'd4,
    E_LD_ACCESS_FAULT    = 4'd5,
    E_ST_ADDR_MISALIGNED = 4'd6,
    E_ST_ACCESS_FAULT    = 4'd7,
    E_ECALL_M            = 4'd11
  } except_code_t;

  // source of the CSR write data
  typedef enum logic [2:0] {
    CSR_SEL_RES,     // instr result / faulting address
    CSR_SEL_PC,      // instr pc
    CSR_SEL_EXCEPT,  // exception code
    CSR_SEL_INSN,    // instr word
    CSR_SEL_ZERO
  } csr_sel_t;

  // write request from the commit cu
  typedef struct packed {
    logic      valid;
    csr_addr_t addr;   // also the read address
    csr_sel_t  sel;
  } csr_wr_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the commit stage testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f filelist.f --top-module tb_commit_stage -o tb_commit_stage

./obj_dir/tb_commit_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
  exit 1
fi
grep -q "TEST PASS" sim.log
